//--- logic/pixel_fifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "vga_consts.svh"

module pixel_fifo #(
	parameter int DEPTH = `VGA_FIFO_DEPTH
) (
	input wire logic pi_clk,
	input wire logic pi_rst_n,
	input wire logic wr_req,
	input wire vga_pkg::pixel_u wr_data,
	output logic wr_ack,
	input wire logic rd_req,
	output vga_pkg::pixel_u rd_data,
	output logic underflow
);

	// index width, pointers carry one extra wrap bit
	localparam int AW = $clog2(DEPTH);

	vga_pkg::pixel_u mem [DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [AW:0] fill;
	logic full;
	logic empty;
	logic do_write;
	logic do_read;

	assign fill = wr_ptr - rd_ptr;
	assign full = (fill == (AW + 1)'(DEPTH));
	assign empty = (fill == '0);

	// accept only from idle, ack low means no word taken yet
	assign do_write = wr_req && !wr_ack && !full;
	// pop only when something is stored
	assign do_read = rd_req && !empty;

	// four-phase write state held in the ack flop
	// low is idle, high is acked and waiting for req to drop
	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
			wr_ack <= 1'b0;
		else if (do_write)
			wr_ack <= 1'b1;
		else if (wr_ack && !wr_req)
			wr_ack <= 1'b0;
	end

	// pointers and sticky underflow
	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			underflow <= 1'b0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= wr_ptr + (AW + 1)'(1);
			if (do_read)
				rd_ptr <= rd_ptr + (AW + 1)'(1);
			// stays set until reset
			if (rd_req && empty)
				underflow <= 1'b1;
		end
	end

	// storage
	always_ff @(posedge pi_clk)
	begin
		if (do_write)
			mem[wr_ptr[AW-1:0]] <= wr_data;
	end

	// registered read, zero word when popped empty
	always_ff @(posedge pi_clk)
	begin
		if (rd_req)
			rd_data <= empty ? '0 : mem[rd_ptr[AW-1:0]];
	end

endmodule

`default_nettype wire

//--- logic/pixel_format.sv
`timescale 1ns/100ps
`default_nettype none
`include "vga_consts.svh"

module pixel_format (
	input wire logic pi_clk,
	input wire logic pi_rst_n,
	input wire vga_pkg::pixel_u pix,
	input wire vga_pkg::scan_ctl_s scan_ctl,
	output vga_pkg::pixel_u rgb
);

	// luma weights at word width
	localparam logic [15:0] K_R = 16'(`VGA_LUMA_R);
	localparam logic [15:0] K_G = 16'(`VGA_LUMA_G);
	localparam logic [15:0] K_B = 16'(`VGA_LUMA_B);
	localparam logic [15:0] K_OFS = 16'(`VGA_LUMA_OFS);

	// luma scaled by 256, peak 59285 fits in 16 bits
	logic [15:0] luma;
	// top five luma bits, shared by all channels
	logic [4:0] y5;
	vga_pkg::pixel_u gray_px;

	// luma stage, one cycle ahead of the output register
	always_ff @(posedge pi_clk)
	begin
		luma <= K_R * {11'd0, pix.chan.r}
			+ K_G * {10'd0, pix.chan.g}
			+ K_B * {11'd0, pix.chan.b}
			+ K_OFS;
	end

	assign y5 = luma[15:11];

	// gray pixel, green gets a zero low bit for its 6-bit field
	always_comb
	begin
		gray_px.chan.r = y5;
		gray_px.chan.g = {y5, 1'b0};
		gray_px.chan.b = y5;
	end

	// output register
	// blank forces zero, gray uses the luma stage, color passes the raw word
	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
			rgb <= '0;
		else if (!scan_ctl.active)
			rgb <= '0;
		else if (scan_ctl.gray)
			rgb <= gray_px;
		else
			rgb.raw <= pix.raw;
	end

endmodule

`default_nettype wire

//--- logic/vga_consts.svh
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

// default raster is 640x480 at 60 Hz on a 25 MHz pixel clock
// horizontal, in pixel clocks
// sync width
`define VGA_HA 96
// back porch
`define VGA_HB 48
// visible pixels
`define VGA_HC 640
// front porch
`define VGA_HD 16

// vertical, in lines
// sync width
`define VGA_VA 2
// back porch
`define VGA_VB 33
// visible lines
`define VGA_VC 480
// front porch
`define VGA_VD 10

// pixel fifo entries, power of two and at least 2
`define VGA_FIFO_DEPTH 8

// luma weights for rgb565 fields, result scaled by 256
// roughly 0.183 r8, 0.614 g8 and 0.062 b8, plus 16 offset
`define VGA_LUMA_R 375
`define VGA_LUMA_G 629
`define VGA_LUMA_B 127
`define VGA_LUMA_OFS 4096

`endif

//--- logic/vga_display.sv
`timescale 1ns/100ps
`default_nettype none
`include "vga_consts.svh"

module vga_display #(
	parameter int HA = `VGA_HA,
	parameter int HB = `VGA_HB,
	parameter int HC = `VGA_HC,
	parameter int HD = `VGA_HD,
	parameter int VA = `VGA_VA,
	parameter int VB = `VGA_VB,
	parameter int VC = `VGA_VC,
	parameter int VD = `VGA_VD,
	parameter int FIFO_DEPTH = `VGA_FIFO_DEPTH
) (
	input wire logic pi_clk,
	input wire logic pi_rst_n,
	input wire logic gray_mode,
	input wire logic wr_req,
	input wire vga_pkg::pixel_u wr_data,
	output logic wr_ack,
	output logic hs,
	output logic vs,
	output vga_pkg::pixel_u rgb,
	output logic underflow
);

	// prefetch read from timing to fifo
	logic rd_req;
	// popped pixel, one cycle after rd_req
	vga_pkg::pixel_u rd_data;
	// active and mode, aligned with rd_data
	vga_pkg::scan_ctl_s scan_ctl;

	// raster counters, sync and read scheduling
	vga_timing #(
		.HA(HA),
		.HB(HB),
		.HC(HC),
		.HD(HD),
		.VA(VA),
		.VB(VB),
		.VC(VC),
		.VD(VD)
	) u_timing (
		.pi_clk(pi_clk),
		.pi_rst_n(pi_rst_n),
		.gray_mode(gray_mode),
		.hs(hs),
		.vs(vs),
		.rd_req(rd_req),
		.scan_ctl(scan_ctl)
	);

	// host pixel queue
	pixel_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_fifo (
		.pi_clk(pi_clk),
		.pi_rst_n(pi_rst_n),
		.wr_req(wr_req),
		.wr_data(wr_data),
		.wr_ack(wr_ack),
		.rd_req(rd_req),
		.rd_data(rd_data),
		.underflow(underflow)
	);

	// color or luma output with blanking
	pixel_format u_format (
		.pi_clk(pi_clk),
		.pi_rst_n(pi_rst_n),
		.pix(rd_data),
		.scan_ctl(scan_ctl),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

//--- logic/vga_pkg.sv
`default_nettype none

package vga_pkg;

	// rgb565 pixel with red in the top bits
	typedef struct packed
	{
		// red in 5 bits
		logic [4:0] r;
		// green in 6 bits
		logic [5:0] g;
		// blue in 5 bits
		logic [4:0] b;
	} rgb565_s;

	// one pixel word seen two ways
	// chan for per-channel math and raw for the plain 16-bit word
	typedef union packed
	{
		rgb565_s chan;
		logic [15:0] raw;
	} pixel_u;

	// timing generator to formatter aligned with fifo read data
	typedef struct packed
	{
		// column and line inside the visible window
		logic active;
		// frame is in luma-only mode
		logic gray;
	} scan_ctl_s;

endpackage

`default_nettype wire

//--- logic/vga_timing.sv
`timescale 1ns/100ps
`default_nettype none
`include "vga_consts.svh"

module vga_timing #(
	parameter int HA = `VGA_HA,
	parameter int HB = `VGA_HB,
	parameter int HC = `VGA_HC,
	parameter int HD = `VGA_HD,
	parameter int VA = `VGA_VA,
	parameter int VB = `VGA_VB,
	parameter int VC = `VGA_VC,
	parameter int VD = `VGA_VD
) (
	input wire logic pi_clk,
	input wire logic pi_rst_n,
	input wire logic gray_mode,
	output logic hs,
	output logic vs,
	output logic rd_req,
	output vga_pkg::scan_ctl_s scan_ctl
);

	// full line and frame lengths
	localparam int HE = HA + HB + HC + HD;
	localparam int VE = VA + VB + VC + VD;
	// room for h plus the largest read lead without wrapping
	localparam int HW = $clog2(HE + 4);
	localparam int VW = $clog2(VE + 1);

	localparam logic [HW-1:0] H_LAST = HW'(HE - 1);
	localparam logic [HW-1:0] H_SYNC = HW'(HA);
	localparam logic [HW-1:0] H_ON = HW'(HA + HB);
	localparam logic [HW-1:0] H_OFF = HW'(HA + HB + HC);
	localparam logic [VW-1:0] V_LAST = VW'(VE - 1);
	localparam logic [VW-1:0] V_SYNC = VW'(VA);
	localparam logic [VW-1:0] V_ON = VW'(VA + VB);
	localparam logic [VW-1:0] V_OFF = VW'(VA + VB + VC);

	logic [HW-1:0] h_cnt;
	logic [VW-1:0] v_cnt;
	logic frame_gray;
	// column the next read is fetched for
	logic [HW-1:0] rd_col;
	// column the formatter sees on the next cycle
	logic [HW-1:0] fmt_col;

	// visible window test
	// columns past the line end never count as visible
	function automatic logic in_window(input logic [HW-1:0] hh, input logic [VW-1:0] vv);
		in_window = (hh >= H_ON) && (hh < H_OFF) && (vv >= V_ON) && (vv < V_OFF);
	endfunction

	// gray path carries one extra luma stage, so it reads one cycle sooner
	assign rd_col = h_cnt + (frame_gray ? HW'(3) : HW'(2));
	assign fmt_col = h_cnt + HW'(1);

	// pixel and line counters
	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (h_cnt == H_LAST)
		begin
			h_cnt <= '0;
			// line steps only at the end of a line
			v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + VW'(1);
		end
		else
		begin
			h_cnt <= h_cnt + HW'(1);
		end
	end

	// registered sync, low during the sync width, idle high
	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
		begin
			hs <= 1'b1;
			vs <= 1'b1;
		end
		else
		begin
			hs <= (h_cnt >= H_SYNC);
			vs <= (v_cnt >= V_SYNC);
		end
	end

	// frame mode sampled once, at the first pixel of the frame
	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
			frame_gray <= 1'b0;
		else if ((h_cnt == '0) && (v_cnt == '0))
			frame_gray <= gray_mode;
	end

	// prefetch read ahead of the window and active flag for the formatter
	// active is looked up one column ahead so it lines up with rd_data
	always_ff @(posedge pi_clk or negedge pi_rst_n)
	begin
		if (!pi_rst_n)
		begin
			rd_req <= 1'b0;
			scan_ctl <= '0;
		end
		else
		begin
			rd_req <= in_window(rd_col, v_cnt);
			scan_ctl.active <= in_window(fmt_col, v_cnt);
			scan_ctl.gray <= frame_gray;
		end
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+logic
logic/vga_pkg.sv
logic/vga_timing.sv
logic/pixel_fifo.sv
logic/pixel_format.sv
logic/vga_display.sv
verification/vga_display_sva.sv
verification/tb_vga_display.sv

//--- verification/tb_vga_display.sv
`timescale 1ns/100ps
`default_nettype none
`include "vga_consts.svh"

module tb_vga_display;

	// tiny raster of HE*VE = 140 cycles per frame
	localparam int HA = 4;
	localparam int HB = 6;
	localparam int HC = 4;
	localparam int HD = 6;
	localparam int VA = 1;
	localparam int VB = 2;
	localparam int VC = 3;
	localparam int VD = 1;
	localparam int HE = HA + HB + HC + HD;
	localparam int VE = VA + VB + VC + VD;
	localparam int NPIX = HC * VC;
	localparam int NROW = 4;
	// longest wait for any handshake edge
	localparam int ACK_LIMIT = HE * VE;

	// one frame of stimulus with words and expected rgb in scan order
	typedef struct packed
	{
		logic gray;
		vga_pkg::pixel_u [0:NPIX-1] pix;
		vga_pkg::pixel_u [0:NPIX-1] exp;
	} frame_row_s;

	frame_row_s tbl [NROW];

	logic pi_clk;
	logic pi_rst_n;
	logic gray_mode;
	logic wr_req;
	vga_pkg::pixel_u wr_data;
	logic wr_ack;
	logic hs;
	logic vs;
	vga_pkg::pixel_u rgb;
	logic underflow;
	// longest ack wait of the current frame in cycles
	int max_wait;

	vga_display #(
		.HA(HA),
		.HB(HB),
		.HC(HC),
		.HD(HD),
		.VA(VA),
		.VB(VB),
		.VC(VC),
		.VD(VD)
	) u_vga_display (
		.pi_clk(pi_clk),
		.pi_rst_n(pi_rst_n),
		.gray_mode(gray_mode),
		.wr_req(wr_req),
		.wr_data(wr_data),
		.wr_ack(wr_ack),
		.hs(hs),
		.vs(vs),
		.rgb(rgb),
		.underflow(underflow)
	);

	// 8 ns clock
	initial
	begin
		pi_clk = 1'b0;
		forever #4 pi_clk = ~pi_clk;
	end

	// luma from the rgb565 fields
	// top five bits fill every channel
	function automatic vga_pkg::pixel_u luma_pixel(input vga_pkg::pixel_u w);
		int sum;
		logic [4:0] y;
		vga_pkg::pixel_u o;
		sum = `VGA_LUMA_R * w.chan.r + `VGA_LUMA_G * w.chan.g
			+ `VGA_LUMA_B * w.chan.b + `VGA_LUMA_OFS;
		y = sum[15:11];
		o.chan.r = y;
		o.chan.g = {y, 1'b0};
		o.chan.b = y;
		return o;
	endfunction

	// table row with expected words filled in per mode
	function automatic frame_row_s make_row(input logic gray,
		input logic [0:NPIX-1][15:0] words);
		frame_row_s row;
		row.gray = gray;
		for (int k = 0; k < NPIX; k++)
		begin
			row.pix[k] = words[k];
			if (gray)
				row.exp[k] = luma_pixel(row.pix[k]);
			else
				row.exp[k] = row.pix[k];
		end
		return row;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_pixel(input string name, input vga_pkg::pixel_u got,
		input vga_pkg::pixel_u exp);
		if (got !== exp)
			abort_run($sformatf("ERROR t=%0t %s got %h expected %h", $time, name,
				got.raw, exp.raw));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("ERROR t=%0t %s got %b expected %b", $time, name, got, exp));
	endtask

	// bound checker failures stop the run on the next edge
	initial
	begin
		forever
		begin
			@(posedge pi_clk);
			if (u_vga_display.u_sva.fail_count != 0)
				abort_run("a concurrent assertion in the bound checker failed");
		end
	end

	// returns on the first sampled cycle with vs low
	task automatic wait_frame_start();
		int n;
		n = 0;
		@(posedge pi_clk);
		while (vs !== 1'b0)
		begin
			n++;
			if (n > 2 * HE * VE)
				abort_run("timeout: vs never went low for a new frame");
			@(posedge pi_clk);
		end
	endtask

	// one four-phase write after a random idle gap
	task automatic write_word(input vga_pkg::pixel_u w);
		int n;
		int gap;
		gap = $urandom % 4;
		repeat (gap) @(posedge pi_clk);
		#1;
		wr_req = 1'b1;
		wr_data = w;
		n = 0;
		@(posedge pi_clk);
		// held high through back-pressure
		while (wr_ack !== 1'b1)
		begin
			n++;
			if (n > ACK_LIMIT)
				abort_run("timeout: wr_ack never rose for a held write request");
			@(posedge pi_clk);
		end
		if (n > max_wait)
			max_wait = n;
		#1;
		wr_req = 1'b0;
		n = 0;
		@(posedge pi_clk);
		while (wr_ack !== 1'b0)
		begin
			n++;
			if (n > 8)
				abort_run("timeout: wr_ack stayed high after wr_req dropped");
			@(posedge pi_clk);
		end
	endtask

	task automatic write_frame(input frame_row_s row);
		max_wait = 0;
		for (int k = 0; k < NPIX; k++)
			write_word(row.pix[k]);
	endtask

	// every cycle of one frame starting where vs fell
	task automatic check_frame(input frame_row_s row, input logic no_data);
		int j;
		int k;
		vga_pkg::pixel_u exp;
		for (int l = 0; l < VE; l++)
			for (int o = 0; o < HE; o++)
			begin
				// first cycle was already sampled by wait_frame_start
				if (l != 0 || o != 0)
					@(posedge pi_clk);
				check_flag("hs", hs, o >= HA);
				check_flag("vs", vs, l >= VA);
				j = l - VA - VB;
				k = o - HA - HB;
				exp = '0;
				if (!no_data && j >= 0 && j < VC && k >= 0 && k < HC)
					exp = row.exp[HC * j + k];
				check_pixel($sformatf("rgb line %0d col %0d", l, o), rgb, exp);
				if (no_data && l == 0 && o == 0)
					check_flag("underflow", underflow, 1'b0);
				// sticky once the first visible line read an empty fifo
				if (l == VA + VB && o == HE - 1)
					check_flag("underflow", underflow, 1'b1);
			end
	endtask

	initial
	begin
		void'($urandom(95));
		pi_rst_n = 1'b0;
		gray_mode = 1'b0;
		wr_req = 1'b0;
		wr_data = '0;
		// primaries, extremes and mixed words
		tbl[0] = make_row(1'b0, {16'hf800, 16'h07e0, 16'h001f, 16'hffff,
			16'h1234, 16'h5678, 16'h9abc, 16'hdef0,
			16'h0001, 16'h8000, 16'h7bef, 16'h0842});
		tbl[1] = make_row(1'b1, {16'h0000, 16'hffff, 16'hf800, 16'h07e0,
			16'h001f, 16'h8410, 16'h4208, 16'hc618,
			16'h2945, 16'hb5b6, 16'h6b4d, 16'h39e7});
		tbl[2] = make_row(1'b0, {16'ha5a5, 16'h5a5a, 16'h0ff0, 16'hf00f,
			16'h3c3c, 16'hc3c3, 16'h1111, 16'heeee,
			16'h2222, 16'hdddd, 16'h4444, 16'hbbbb});
		tbl[3] = make_row(1'b1, {16'h7fff, 16'hfffe, 16'h0020, 16'h0800,
			16'h0400, 16'h003f, 16'hf81f, 16'h07ff,
			16'hffe0, 16'h1357, 16'h2468, 16'hace1});
		repeat (5) @(posedge pi_clk);
		#1;
		pi_rst_n = 1'b1;
		// first frame has no writes so reads hit an empty fifo
		wait_frame_start();
		fork
			check_frame(tbl[0], 1'b1);
			begin
				#1;
				gray_mode = tbl[0].gray;
			end
		join
		for (int r = 0; r < NROW; r++)
		begin
			wait_frame_start();
			fork
				check_frame(tbl[r], 1'b0);
				write_frame(tbl[r]);
				// mode for the next frame latched at its first pixel
				begin
					#1;
					gray_mode = (r + 1 < NROW) ? tbl[r + 1].gray : 1'b0;
				end
			join
			// 8 words fill the fifo long before the first visible line
			if (max_wait < 4)
				abort_run("no back-pressure seen: wr_ack was never held low on a full FIFO");
		end
		if (u_vga_display.u_sva.fail_count == 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("concurrent assertions failed %0d times",
				u_vga_display.u_sva.fail_count);
			$display("TEST FAIL");
			$fatal(1, "assertion failures in the run");
		end
	end

endmodule

`default_nettype wire

//--- verification/vga_display_sva.sv
`timescale 1ns/100ps
`default_nettype none

module vga_display_sva (
	input wire logic pi_clk,
	input wire logic pi_rst_n,
	input wire logic wr_req,
	input wire vga_pkg::pixel_u wr_data,
	input wire logic wr_ack,
	input wire logic hs,
	input wire logic vs,
	input wire vga_pkg::pixel_u rgb
);

	// failing assertions so far
	int fail_count = 0;

	// ack only answers a pending request
	ack_needs_req: assert property (@(posedge pi_clk) disable iff (!pi_rst_n)
		$rose(wr_ack) |-> $past(wr_req))
	else
	begin
		$error("wr_ack rose without wr_req");
		fail_count++;
	end

	// request and data held until acked
	req_held: assert property (@(posedge pi_clk) disable iff (!pi_rst_n)
		(wr_req && !wr_ack) |=> (wr_req && $stable(wr_data)))
	else
	begin
		$error("wr_req or wr_data changed before wr_ack");
		fail_count++;
	end

	// sync intervals are always blank
	blank_in_sync: assert property (@(posedge pi_clk) disable iff (!pi_rst_n)
		(!hs || !vs) |-> (rgb.raw == '0))
	else
	begin
		$error("rgb not zero during sync");
		fail_count++;
	end

endmodule

bind vga_display vga_display_sva u_sva (
	.pi_clk(pi_clk),
	.pi_rst_n(pi_rst_n),
	.wr_req(wr_req),
	.wr_data(wr_data),
	.wr_ack(wr_ack),
	.hs(hs),
	.vs(vs),
	.rgb(rgb)
);

`default_nettype wire
